/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = lsu_tb
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* lsu_ad.sv */
// Loads and stores only; unused funct3 codes fall back to word size, any other opcode is a load
`timescale 1ns/100ps

module lsu_ad (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   i_flush,

    // Reservation station side
    input  lsu_pkg::lsu_op_t       i_op,
    output logic                   o_stall,

    // Store queue side
    input  lsu_pkg::lsu_sq_entry_t i_sq_head,
    input  logic                   i_sq_head_valid,
    input  logic                   i_sq_full,
    input  logic                   i_sq_empty,
    output lsu_pkg::lsu_sq_entry_t o_alloc,
    output logic                   o_alloc_en,
    output logic                   o_sq_retire_en,

    // Memory stage request
    output lsu_pkg::lsu_mem_req_t  o_req
);

    lsu_pkg::lsu_func_t             func;
    lsu_pkg::lsu_mem_req_t          req_next;
    logic                           is_store;
    logic [2:0]                     funct3;
    logic [lsu_pkg::DATA_WIDTH-1:0] imm_i;
    logic [lsu_pkg::DATA_WIDTH-1:0] imm_s;
    logic [lsu_pkg::DATA_WIDTH-1:0] addr;
    logic                           accept;
    logic                           load_go;

    assign is_store = (i_op.opcode == lsu_pkg::OPCODE_STORE);

    // funct3 sits at the same place in both views
    assign funct3 = i_op.insn.i_type.funct3;

    // Immediates from the two views of the same word
    assign imm_i = {{(lsu_pkg::DATA_WIDTH-12){i_op.insn.i_type.imm[11]}},
                    i_op.insn.i_type.imm};
    assign imm_s = {{(lsu_pkg::DATA_WIDTH-12){i_op.insn.s_type.imm_11_5[6]}},
                    i_op.insn.s_type.imm_11_5, i_op.insn.s_type.imm_4_0};

    assign addr = i_op.src_a + (is_store ? imm_s : imm_i);

    always_comb begin
        case (funct3)
            3'b000:  func = is_store ? lsu_pkg::LSU_FUNC_SB : lsu_pkg::LSU_FUNC_LB;
            3'b001:  func = is_store ? lsu_pkg::LSU_FUNC_SH : lsu_pkg::LSU_FUNC_LH;
            3'b100:  func = is_store ? lsu_pkg::LSU_FUNC_SW : lsu_pkg::LSU_FUNC_LBU;
            3'b101:  func = is_store ? lsu_pkg::LSU_FUNC_SW : lsu_pkg::LSU_FUNC_LHU;
            default: func = is_store ? lsu_pkg::LSU_FUNC_SW : lsu_pkg::LSU_FUNC_LW;
        endcase
    end

    // Loads wait for a drained queue, stores wait for a free slot
    assign o_stall = i_op.valid & (is_store ? i_sq_full : ~i_sq_empty);
    assign accept  = i_op.valid & ~o_stall & ~i_flush;
    assign load_go = accept & ~is_store;

    // The committed head is always taken at once
    assign o_sq_retire_en = i_sq_head_valid;

    // Retiring store has priority on the memory port
    always_comb begin
        if (i_sq_head_valid) begin
            req_next.valid = 1'b1;
            req_next.write = 1'b1;
            req_next.func  = i_sq_head.func;
            req_next.tag   = i_sq_head.tag;
            req_next.addr  = i_sq_head.addr;
            req_next.data  = i_sq_head.data;
        end else begin
            req_next.valid = load_go;
            req_next.write = 1'b0;
            req_next.func  = func;
            req_next.tag   = i_op.tag;
            req_next.addr  = addr;
            req_next.data  = i_op.src_b;
        end
    end

    always_ff @(posedge clk) begin
        o_req <= req_next;
        if (!n_rst) begin
            o_req.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        o_alloc.func <= func;
        o_alloc.tag  <= i_op.tag;
        o_alloc.addr <= addr;
        o_alloc.data <= i_op.src_b;
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_alloc_en <= 1'b0;
        end else begin
            o_alloc_en <= accept & is_store;
        end
    end

    // A load must never share the memory port with a retire
    a_port_conflict: assert property (@(posedge clk) disable iff (!n_rst)
        !(o_sq_retire_en && load_go));

endmodule

/* lsu_dmem.sv */
// DMEM_WORDS must be a power of two; address bits above the array wrap, accesses must be aligned
`timescale 1ns/100ps

module lsu_dmem #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  lsu_pkg::lsu_mem_req_t i_req,
    output lsu_pkg::lsu_result_t  o_result
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [lsu_pkg::DATA_WIDTH-1:0] mem [DMEM_WORDS];
    logic [AW-1:0]                  idx;
    logic [3:0]                     be;
    logic [lsu_pkg::DATA_WIDTH-1:0] wdata;
    logic [lsu_pkg::DATA_WIDTH-1:0] rdata;
    logic [lsu_pkg::DATA_WIDTH-1:0] rshift;
    lsu_pkg::lsu_result_t           result_next;

    assign idx = i_req.addr[AW+1:2];

    // Byte lanes and replicated write data
    always_comb begin
        case (i_req.func)
            lsu_pkg::LSU_FUNC_SB: begin
                be    = 4'b0001 << i_req.addr[1:0];
                wdata = {4{i_req.data[7:0]}};
            end
            lsu_pkg::LSU_FUNC_SH: begin
                be    = 4'b0011 << {i_req.addr[1], 1'b0};
                wdata = {2{i_req.data[15:0]}};
            end
            lsu_pkg::LSU_FUNC_SW: begin
                be    = 4'b1111;
                wdata = i_req.data;
            end
            default: begin
                be    = 4'b0000;
                wdata = i_req.data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_req.valid && i_req.write) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Aligned read, byte or halfword shifted down to bit 0
    assign rdata  = mem[idx];
    assign rshift = rdata >> {i_req.addr[1:0], 3'b000};

    always_comb begin
        result_next.valid    = i_req.valid;
        result_next.is_store = i_req.write;
        result_next.tag      = i_req.tag;
        case (i_req.func)
            lsu_pkg::LSU_FUNC_LB:  result_next.data = {{24{rshift[7]}}, rshift[7:0]};
            lsu_pkg::LSU_FUNC_LBU: result_next.data = {24'd0, rshift[7:0]};
            lsu_pkg::LSU_FUNC_LH:  result_next.data = {{16{rshift[15]}}, rshift[15:0]};
            lsu_pkg::LSU_FUNC_LHU: result_next.data = {16'd0, rshift[15:0]};
            lsu_pkg::LSU_FUNC_LW:  result_next.data = rdata;
            // Stores report the data they wrote
            default:               result_next.data = i_req.data;
        endcase
    end

    always_ff @(posedge clk) begin
        o_result <= result_next;
        if (!n_rst) begin
            o_result.valid <= 1'b0;
        end
    end

    a_aligned: assert property (@(posedge clk) disable iff (!n_rst)
        i_req.valid |->
            !((i_req.func inside {lsu_pkg::LSU_FUNC_LH, lsu_pkg::LSU_FUNC_LHU,
                                  lsu_pkg::LSU_FUNC_SH}) && i_req.addr[0]) &&
            !((i_req.func inside {lsu_pkg::LSU_FUNC_LW, lsu_pkg::LSU_FUNC_SW}) &&
              (i_req.addr[1:0] != 2'b00)));

endmodule

/* lsu_pkg.sv */
// Shared LSU types; RV32 load/store encodings only, 32-bit data assumed by the byte-lane logic
package lsu_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH  = 6;

    // Major opcodes as in the RV32I base encoding
    typedef enum logic [6:0] {
        OPCODE_LOAD  = 7'b0000011,
        OPCODE_STORE = 7'b0100011
    } lsu_opcode_t;

    typedef enum logic [3:0] {
        LSU_FUNC_LB  = 4'd0,
        LSU_FUNC_LH  = 4'd1,
        LSU_FUNC_LW  = 4'd2,
        LSU_FUNC_LBU = 4'd3,
        LSU_FUNC_LHU = 4'd4,
        LSU_FUNC_SB  = 4'd5,
        LSU_FUNC_SH  = 4'd6,
        LSU_FUNC_SW  = 4'd7
    } lsu_func_t;

    // I-type view, used by loads
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } lsu_insn_i_t;

    // S-type view, used by stores
    typedef struct packed {
        logic [6:0]  imm_11_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_4_0;
        logic [6:0]  opcode;
    } lsu_insn_s_t;

    typedef union packed {
        lsu_insn_i_t i_type;
        lsu_insn_s_t s_type;
    } lsu_insn_t;

    typedef struct packed {
        logic                  valid;
        lsu_opcode_t           opcode;
        lsu_insn_t             insn;
        logic [DATA_WIDTH-1:0] src_a;
        logic [DATA_WIDTH-1:0] src_b;
        logic [TAG_WIDTH-1:0]  tag;
    } lsu_op_t;

    typedef struct packed {
        lsu_func_t             func;
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } lsu_sq_entry_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        lsu_func_t             func;
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } lsu_mem_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  is_store;
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;
    } lsu_result_t;

endpackage

/* lsu_sq.sv */
// SQ_DEPTH >= 2; full and empty already count an allocate that is in flight this cycle
`timescale 1ns/100ps

module lsu_sq #(
    parameter int SQ_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   i_flush,
    input  lsu_pkg::lsu_sq_entry_t i_alloc,
    input  logic                   i_alloc_en,
    input  logic                   i_commit,
    input  logic                   i_retire_en,
    output lsu_pkg::lsu_sq_entry_t o_head,
    output logic                   o_head_valid,
    output logic                   o_full,
    output logic                   o_empty
);

    localparam int PTR_W = $clog2(SQ_DEPTH);
    localparam int CNT_W = $clog2(SQ_DEPTH + 1);

    lsu_pkg::lsu_sq_entry_t entries [SQ_DEPTH];
    logic [PTR_W-1:0]       head_ptr;
    logic [PTR_W-1:0]       tail_ptr;
    logic [PTR_W-1:0]       head_next;
    logic [PTR_W-1:0]       tail_next;
    logic [CNT_W-1:0]       count;
    logic [CNT_W-1:0]       commit_cnt;
    logic [CNT_W-1:0]       count_next;
    logic [CNT_W-1:0]       commit_next;
    logic [CNT_W:0]         rewind_sum;
    logic                   alloc;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(SQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Flush also kills the allocate arriving this cycle
    assign alloc = i_alloc_en & ~i_flush;

    always_comb begin
        head_next   = i_retire_en ? ptr_inc(head_ptr) : head_ptr;
        commit_next = commit_cnt + CNT_W'(i_commit) - CNT_W'(i_retire_en);
        rewind_sum  = (CNT_W+1)'(head_next) + (CNT_W+1)'(commit_next);

        if (i_flush) begin
            // Keep only committed entries, tail lands right after them
            count_next = commit_next;
            if (rewind_sum >= (CNT_W+1)'(SQ_DEPTH)) begin
                tail_next = PTR_W'(rewind_sum - (CNT_W+1)'(SQ_DEPTH));
            end else begin
                tail_next = PTR_W'(rewind_sum);
            end
        end else begin
            count_next = count + CNT_W'(alloc) - CNT_W'(i_retire_en);
            tail_next  = alloc ? ptr_inc(tail_ptr) : tail_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head_ptr   <= '0;
            tail_ptr   <= '0;
            count      <= '0;
            commit_cnt <= '0;
        end else begin
            head_ptr   <= head_next;
            tail_ptr   <= tail_next;
            count      <= count_next;
            commit_cnt <= commit_next;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entries[tail_ptr] <= i_alloc;
        end
    end

    assign o_head       = entries[head_ptr];
    assign o_head_valid = (commit_cnt != '0);

    assign o_full  = (count == CNT_W'(SQ_DEPTH)) |
                     (i_alloc_en & (count == CNT_W'(SQ_DEPTH - 1)));
    assign o_empty = (count == '0) & ~i_alloc_en;

    // Commits only ever refer to a store already in the queue
    a_commit_has_entry: assert property (@(posedge clk) disable iff (!n_rst)
        i_commit |-> (count > commit_cnt));

    a_retire_head_valid: assert property (@(posedge clk) disable iff (!n_rst)
        i_retire_en |-> o_head_valid);

    // An allocate never lands in a queue that is already full
    a_alloc_not_full: assert property (@(posedge clk) disable iff (!n_rst)
        alloc |-> (count < CNT_W'(SQ_DEPTH)));

endmodule

/* lsu_tb.sv */
// LSU testbench with SQ_DEPTH 4; loads only touch words written earlier, since memory has no reset
`timescale 1ns/100ps

module lsu_tb;

    typedef struct packed {
        logic        has_op;
        logic        is_store;
        logic [2:0]  funct3;
        logic [31:0] base;
        logic [11:0] imm;
        logic        commit;
        logic        flush;
        logic        exp_stall;
    } step_t;

    logic                 clk;
    logic                 n_rst;
    logic                 i_flush;
    logic                 i_commit;
    lsu_pkg::lsu_op_t     i_op;
    logic                 o_stall;
    lsu_pkg::lsu_result_t o_result;

    step_t                  steps[$];
    lsu_pkg::lsu_sq_entry_t pending[$];
    lsu_pkg::lsu_result_t   exp_q[$];
    int                     due_q[$];
    logic [31:0]            mm [logic [29:0]];
    logic [31:0]            seed = 32'ha5b6;
    int                     cyc = 0;
    int                     limit = 100000;
    int                     errors = 0;
    int                     checks = 0;

    tb_clkgen u_clkgen (
        .o_clk   (clk),
        .o_n_rst (n_rst)
    );

    lsu_top #(
        .SQ_DEPTH   (4),
        .DMEM_WORDS (256)
    ) UUT (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_flush  (i_flush),
        .i_commit (i_commit),
        .i_op     (i_op),
        .o_stall  (o_stall),
        .o_result (o_result)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic void add_step(input logic has_op, input logic is_store,
                                     input logic [2:0] funct3, input logic [31:0] base,
                                     input logic [11:0] imm, input logic commit,
                                     input logic flush, input logic exp_stall);
        steps.push_back({has_op, is_store, funct3, base, imm, commit, flush, exp_stall});
    endfunction

    // funct3 to access size, per the RV32I load and store encodings
    function automatic lsu_pkg::lsu_func_t model_func(input logic st, input logic [2:0] f3);
        case (f3)
            3'd0:    return st ? lsu_pkg::LSU_FUNC_SB : lsu_pkg::LSU_FUNC_LB;
            3'd1:    return st ? lsu_pkg::LSU_FUNC_SH : lsu_pkg::LSU_FUNC_LH;
            3'd4:    return st ? lsu_pkg::LSU_FUNC_SW : lsu_pkg::LSU_FUNC_LBU;
            3'd5:    return st ? lsu_pkg::LSU_FUNC_SW : lsu_pkg::LSU_FUNC_LHU;
            default: return st ? lsu_pkg::LSU_FUNC_SW : lsu_pkg::LSU_FUNC_LW;
        endcase
    endfunction

    function automatic logic [31:0] load_ref(input lsu_pkg::lsu_func_t f, input logic [31:0] a);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = mm.exists(a[31:2]) ? mm[a[31:2]] : 32'hx;
        b = w[8*a[1:0] +: 8];
        h = w[16*a[1] +: 16];
        case (f)
            lsu_pkg::LSU_FUNC_LB:  return {{24{b[7]}}, b};
            lsu_pkg::LSU_FUNC_LBU: return {24'd0, b};
            lsu_pkg::LSU_FUNC_LH:  return {{16{h[15]}}, h};
            lsu_pkg::LSU_FUNC_LHU: return {16'd0, h};
            default:               return w;
        endcase
    endfunction

    // Committed store lands in the model memory and is reported in queue order
    function automatic void commit_ref();
        lsu_pkg::lsu_sq_entry_t e;
        logic [31:0]            w;
        e = pending.pop_front();
        w = mm.exists(e.addr[31:2]) ? mm[e.addr[31:2]] : 32'd0;
        case (e.func)
            lsu_pkg::LSU_FUNC_SB: w[8*e.addr[1:0] +: 8] = e.data[7:0];
            lsu_pkg::LSU_FUNC_SH: w[16*e.addr[1] +: 16] = e.data[15:0];
            default:              w = e.data;
        endcase
        mm[e.addr[31:2]] = w;
        exp_q.push_back({1'b1, 1'b1, e.tag, e.data});
        due_q.push_back(-1);
    endfunction

    task automatic check_result(input lsu_pkg::lsu_result_t got,
                                input lsu_pkg::lsu_result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %0t ns o_result got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %0t ns o_stall got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic run_step(input step_t s, input logic [5:0] tag);
        lsu_pkg::lsu_op_t op;
        logic [31:0]      addr;
        int               waited;
        op = '0;
        addr = s.base + {{20{s.imm[11]}}, s.imm};
        op.valid = s.has_op;
        op.opcode = s.is_store ? lsu_pkg::OPCODE_STORE : lsu_pkg::OPCODE_LOAD;
        if (s.is_store) begin
            op.insn.s_type.opcode = lsu_pkg::OPCODE_STORE;
            op.insn.s_type.funct3 = s.funct3;
            op.insn.s_type.rs1 = 5'd1;
            op.insn.s_type.rs2 = 5'd2;
            op.insn.s_type.imm_11_5 = s.imm[11:5];
            op.insn.s_type.imm_4_0 = s.imm[4:0];
            seed = xorshift(seed);
            op.src_b = seed;
        end else begin
            op.insn.i_type.opcode = lsu_pkg::OPCODE_LOAD;
            op.insn.i_type.funct3 = s.funct3;
            op.insn.i_type.rs1 = 5'd1;
            op.insn.i_type.rd = 5'd3;
            op.insn.i_type.imm = s.imm;
        end
        op.src_a = s.base;
        op.tag = tag;
        i_op = op;
        i_commit = s.commit;
        i_flush = s.flush;
        if (s.commit) begin
            commit_ref();
        end
        if (s.flush) begin
            pending.delete();
        end
        #1;
        check_stall(o_stall, s.exp_stall);
        if (s.has_op && !s.flush) begin
            waited = 0;
            while (o_stall && waited < 20) begin
                @(negedge clk);
                i_commit = 1'b0;
                waited++;
            end
            if (o_stall) begin
                errors++;
                $display("Op with tag %0d was never accepted, o_stall stayed high", tag);
            end else if (s.is_store) begin
                pending.push_back({model_func(1'b1, s.funct3), tag, addr, op.src_b});
            end else begin
                // Request registers at the next edge, the result one edge later
                exp_q.push_back({1'b1, 1'b0, tag, load_ref(model_func(1'b0, s.funct3), addr)});
                due_q.push_back(cyc + 2);
            end
        end
        @(negedge clk);
        i_op = '0;
        i_commit = 1'b0;
        i_flush = 1'b0;
        // Gap lets an allocate reach the queue before the next commit
        repeat (2) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > limit) begin
            $display("Run stopped after %0d cycles without finishing the steps", cyc);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Every result must match the oldest outstanding prediction
    always @(negedge clk) begin
        int due;
        if (n_rst && o_result.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Result with tag %0d arrived when none was expected", o_result.tag);
            end else begin
                due = due_q.pop_front();
                check_result(o_result, exp_q.pop_front());
                if (due >= 0 && due != cyc) begin
                    errors++;
                    $display("Load result came at cycle %0d instead of %0d", cyc, due);
                end
            end
        end
    end

    initial begin
        i_op = '0;
        i_commit = 1'b0;
        i_flush = 1'b0;
        // SW then every load width and offset
        add_step(1, 1, 3'd2, 32'h100, 12'h000, 0, 0, 0);
        add_step(0, 0, 3'd0, 32'h0, 12'h0, 1, 0, 0);
        for (int i = 0; i < 4; i++) begin
            add_step(1, 0, 3'd0, 32'h100, 12'(i), 0, 0, 0);
            add_step(1, 0, 3'd4, 32'h100, 12'(i), 0, 0, 0);
        end
        for (int i = 0; i < 4; i += 2) begin
            add_step(1, 0, 3'd1, 32'h100, 12'(i), 0, 0, 0);
            add_step(1, 0, 3'd5, 32'h100, 12'(i), 0, 0, 0);
        end
        add_step(1, 0, 3'd2, 32'h100, 12'h000, 0, 0, 0);
        // Byte and halfword merges, then a negative immediate
        add_step(1, 1, 3'd0, 32'h100, 12'h001, 0, 0, 0);
        add_step(1, 1, 3'd1, 32'h100, 12'h002, 0, 0, 0);
        add_step(0, 0, 3'd0, 32'h0, 12'h0, 1, 0, 0);
        add_step(0, 0, 3'd0, 32'h0, 12'h0, 1, 0, 0);
        add_step(1, 0, 3'd2, 32'h100, 12'h000, 0, 0, 0);
        add_step(1, 0, 3'd0, 32'h104, 12'hffd, 0, 0, 0);
        // Load held until the last pending store retires
        add_step(1, 1, 3'd2, 32'h104, 12'h000, 0, 0, 0);
        add_step(1, 1, 3'd2, 32'h108, 12'h000, 0, 0, 0);
        add_step(0, 0, 3'd0, 32'h0, 12'h0, 1, 0, 0);
        add_step(1, 0, 3'd2, 32'h104, 12'h000, 1, 0, 1);
        add_step(1, 0, 3'd2, 32'h108, 12'h000, 0, 0, 0);
        // Fill the queue, the fifth store waits for one retire
        for (int i = 0; i < 4; i++) begin
            add_step(1, 1, 3'd2, 32'h10c + 4 * i, 12'h000, 0, 0, 0);
        end
        add_step(1, 1, 3'd2, 32'h11c, 12'h000, 1, 0, 1);
        for (int i = 0; i < 4; i++) begin
            add_step(0, 0, 3'd0, 32'h0, 12'h0, 1, 0, 0);
        end
        add_step(1, 0, 3'd2, 32'h10c, 12'h000, 0, 0, 0);
        add_step(1, 0, 3'd2, 32'h11c, 12'h000, 0, 0, 0);
        // Flush drops two uncommitted stores and the offered load
        add_step(1, 1, 3'd2, 32'h120, 12'h000, 0, 0, 0);
        add_step(0, 0, 3'd0, 32'h0, 12'h0, 1, 0, 0);
        add_step(1, 1, 3'd2, 32'h120, 12'h000, 0, 0, 0);
        add_step(1, 1, 3'd1, 32'h120, 12'h002, 0, 0, 0);
        add_step(1, 0, 3'd2, 32'h120, 12'h000, 0, 1, 1);
        add_step(1, 0, 3'd2, 32'h120, 12'h000, 0, 0, 0);
        add_step(1, 0, 3'd1, 32'h120, 12'h002, 0, 0, 0);
        limit = steps.size() * 8 + 50;
        @(posedge n_rst);
        @(negedge clk);
        foreach (steps[k]) begin
            run_step(steps[k], 6'(k));
        end
        repeat (6) @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results never arrived", exp_q.size());
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* lsu_top.sv */
// Memory always hits; loads are held back until every older store has left the queue
`timescale 1ns/100ps

module lsu_top #(
    parameter int SQ_DEPTH   = 4,
    parameter int DMEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_flush,
    input  logic                 i_commit,
    input  lsu_pkg::lsu_op_t     i_op,
    output logic                 o_stall,
    output lsu_pkg::lsu_result_t o_result
);

    lsu_pkg::lsu_sq_entry_t sq_head;
    lsu_pkg::lsu_sq_entry_t alloc;
    lsu_pkg::lsu_mem_req_t  req;
    logic                   sq_head_valid;
    logic                   sq_full;
    logic                   sq_empty;
    logic                   alloc_en;
    logic                   retire_en;

    lsu_ad u_ad (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_flush         (i_flush),
        .i_op            (i_op),
        .o_stall         (o_stall),
        .i_sq_head       (sq_head),
        .i_sq_head_valid (sq_head_valid),
        .i_sq_full       (sq_full),
        .i_sq_empty      (sq_empty),
        .o_alloc         (alloc),
        .o_alloc_en      (alloc_en),
        .o_sq_retire_en  (retire_en),
        .o_req           (req)
    );

    lsu_sq #(
        .SQ_DEPTH (SQ_DEPTH)
    ) u_sq (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_flush      (i_flush),
        .i_alloc      (alloc),
        .i_alloc_en   (alloc_en),
        .i_commit     (i_commit),
        .i_retire_en  (retire_en),
        .o_head       (sq_head),
        .o_head_valid (sq_head_valid),
        .o_full       (sq_full),
        .o_empty      (sq_empty)
    );

    lsu_dmem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_req    (req),
        .o_result (o_result)
    );

endmodule

/* tb_clkgen.sv */
// Testbench clock with a 10 ns period; reset is held low for the first 2 rising edges
`timescale 1ns/100ps

module tb_clkgen (
    output logic o_clk,
    output logic o_n_rst
);

    initial begin
        o_clk   = 1'b0;
        o_n_rst = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    initial begin
        repeat (2) @(posedge o_clk);
        o_n_rst <= 1'b1;
    end

endmodule

/* vlog.f */
lsu_pkg.sv
lsu_ad.sv
lsu_sq.sv
lsu_dmem.sv
lsu_top.sv
tb_clkgen.sv
lsu_tb.sv
